// ==== source/simd_params.svh ====
////////////////////////////////////////////////////////////////////////////
// Word and lane geometry plus the saturation clamp values
// Lane geometry is fixed at four byte slices; the clamps assume XLEN = 32
////////////////////////////////////////////////////////////////////////////
`ifndef SIMD_PARAMS_SVH
`define SIMD_PARAMS_SVH

// Data word and byte slice count
`define SIMD_XLEN  32
`define SIMD_LANES 4

// Unsigned clamp, replicated per byte for wider lanes
`define SIMD_SAT_U8_MAX  8'hFF

// Signed clamps per lane width
`define SIMD_SAT_S8_MIN  8'h80
`define SIMD_SAT_S8_MAX  8'h7F
`define SIMD_SAT_S16_MIN 16'h8000
`define SIMD_SAT_S16_MAX 16'h7FFF
`define SIMD_SAT_S32_MIN 32'h8000_0000
`define SIMD_SAT_S32_MAX 32'h7FFF_FFFF

`endif

// ==== source/simd_op_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Operation, lane width and result source encodings
// Encodings are internal to the unit and not tied to the ISA opcode map
////////////////////////////////////////////////////////////////////////////
package simd_op_pkg;

  // Kept packed-SIMD operations
  typedef enum logic [4:0] {
    ADD,
    SUB,
    KADD,
    KSUB,
    UKADD,
    UKSUB,
    RADD,
    RSUB,
    URADD,
    URSUB,
    CMPEQ,
    SCMPLT,
    SCMPLE,
    UCMPLT,
    UCMPLE,
    SMIN,
    SMAX,
    UMIN,
    UMAX
  } simd_op_e;

  // Lane split of the data word
  typedef enum logic [1:0] {
    W8,
    W16,
    W32
  } simd_width_e;

  // Candidate picked by the output stage
  typedef enum logic [2:0] {
    RES_SUM,
    RES_SAT,
    RES_HALF,
    RES_CMP,
    RES_MINMAX
  } simd_res_sel_e;

endpackage

// ==== source/simd_lane_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Per byte slice data types shared by the datapath stages
// Byte sums carry one extension bit (sign or carry) above each byte
////////////////////////////////////////////////////////////////////////////
`include "simd_params.svh"

package simd_lane_pkg;

  // One flag per byte slice, replicated across a lane
  typedef logic [`SIMD_LANES-1:0] simd_lane_flags_t;

  // Bit 8 of each entry is the extension bit
  typedef logic [`SIMD_LANES-1:0][8:0] simd_byte_sums_t;

endpackage

// ==== source/simd_op_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Operation classifier for the packed-SIMD unit
// Purely combinational; compares and min/max all run as subtraction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module simd_op_decoder
  import simd_op_pkg::*;
(
  input  simd_op_e      op_i,
  output logic          sub_o,
  output logic          signed_ops_o,
  output simd_res_sel_e res_sel_o,
  output logic          cmp_or_eq_o,
  output logic          cmp_invert_o
);

  // Compare controls: 00 less, 01 not less, 10 less or equal, 11 equal
  always_comb begin
    sub_o        = 1'b0;
    signed_ops_o = 1'b0;
    res_sel_o    = RES_SUM;
    cmp_or_eq_o  = 1'b0;
    cmp_invert_o = 1'b0;

    unique case (op_i)
      ADD:    ;
      SUB:    sub_o = 1'b1;

      KADD,   UKADD: res_sel_o = RES_SAT;
      KSUB,   UKSUB: begin
        sub_o     = 1'b1;
        res_sel_o = RES_SAT;
      end

      RADD,   URADD: res_sel_o = RES_HALF;
      RSUB,   URSUB: begin
        sub_o     = 1'b1;
        res_sel_o = RES_HALF;
      end

      CMPEQ: begin
        sub_o        = 1'b1;
        res_sel_o    = RES_CMP;
        cmp_or_eq_o  = 1'b1;
        cmp_invert_o = 1'b1;
      end
      SCMPLT, UCMPLT: begin
        sub_o     = 1'b1;
        res_sel_o = RES_CMP;
      end
      SCMPLE, UCMPLE: begin
        sub_o       = 1'b1;
        res_sel_o   = RES_CMP;
        cmp_or_eq_o = 1'b1;
      end

      SMIN,   UMIN: begin
        sub_o     = 1'b1;
        res_sel_o = RES_MINMAX;
      end
      SMAX,   UMAX: begin
        sub_o        = 1'b1;
        res_sel_o    = RES_MINMAX;
        cmp_invert_o = 1'b1;
      end

      default: ;
    endcase

    // Signedness only matters for the extension bits
    unique case (op_i)
      KADD, KSUB, RADD, RSUB, SCMPLT, SCMPLE, SMIN, SMAX: signed_ops_o = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== source/simd_lane_adder.sv ====
////////////////////////////////////////////////////////////////////////////
// Splittable adder built from four 9-bit byte adders
// Carry crosses a byte boundary only inside a lane; no averaging carry-in
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

`include "simd_params.svh"

module simd_lane_adder
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  input  simd_width_e           width_i,
  input  logic                  sub_i,
  input  logic                  signed_ops_i,
  output simd_byte_sums_t       byte_sums_o,
  output logic [`SIMD_XLEN-1:0] sum_o
);

  logic                   width8;
  logic                   width32;
  logic [`SIMD_LANES-1:0] lane_start;
  logic [`SIMD_LANES-1:0] lane_top;

  assign width8  = (width_i == W8);
  assign width32 = (width_i == W32);

  // Byte 0 always opens a lane, byte 3 always closes one
  assign lane_start = {width8, ~width32, width8, 1'b1};
  assign lane_top   = {1'b1, width8, ~width32, width8};

  ////////////////////////////////////////////////////////////////////////////
  // Byte adder chain
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    logic       carry;
    logic       cin;
    logic       ext_a;
    logic       ext_b;
    logic [7:0] b_byte;
    logic [8:0] sum9;

    carry = 1'b0;
    for (int b = 0; b < `SIMD_LANES; b++) begin
      // Subtraction is A + ~B + 1, the one injected at each lane start
      b_byte = operand_b_i[8*b +: 8] ^ {8{sub_i}};
      cin    = lane_start[b] ? sub_i : carry;

      // Sign extension only on the top byte of a signed lane
      ext_a = operand_a_i[8*b+7] & lane_top[b] & signed_ops_i;
      ext_b = b_byte[7] & lane_top[b] & signed_ops_i;

      sum9           = {ext_a, operand_a_i[8*b +: 8]} + {ext_b, b_byte} + {8'h00, cin};
      byte_sums_o[b] = sum9;

      // Bit 8 of an inner byte is a plain carry
      carry = sum9[8];
    end
  end

  // Wrapping lane result
  always_comb begin
    for (int b = 0; b < `SIMD_LANES; b++) begin
      sum_o[8*b +: 8] = byte_sums_o[b][7:0];
    end
  end

endmodule

// ==== source/simd_sat_round.sv ====
////////////////////////////////////////////////////////////////////////////
// Saturating and halving results derived from the extended byte sums
// Flags are replicated across every byte slice of a clamped lane
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

`include "simd_params.svh"

module simd_sat_round
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  simd_byte_sums_t       byte_sums_i,
  input  simd_width_e           width_i,
  input  logic                  sub_i,
  input  logic                  signed_ops_i,
  output logic [`SIMD_XLEN-1:0] sat_result_o,
  output logic [`SIMD_XLEN-1:0] half_result_o,
  output simd_lane_flags_t      lane_sat_o
);

  logic                   width8;
  logic                   width32;
  logic [`SIMD_LANES-1:0] lane_top;
  logic [`SIMD_XLEN-1:0]  clamp_min;
  logic [`SIMD_XLEN-1:0]  clamp_max;
  logic [`SIMD_XLEN-1:0]  clamp_uns;
  logic [`SIMD_LANES-1:0] next_lsb;
  logic                   half_flip;

  assign width8   = (width_i == W8);
  assign width32  = (width_i == W32);
  assign lane_top = {1'b1, width8, ~width32, width8};

  ////////////////////////////////////////////////////////////////////////////
  // Saturation
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (width_i)
      W8: begin
        clamp_min = {4{`SIMD_SAT_S8_MIN}};
        clamp_max = {4{`SIMD_SAT_S8_MAX}};
      end
      W16: begin
        clamp_min = {2{`SIMD_SAT_S16_MIN}};
        clamp_max = {2{`SIMD_SAT_S16_MAX}};
      end
      default: begin
        clamp_min = `SIMD_SAT_S32_MIN;
        clamp_max = `SIMD_SAT_S32_MAX;
      end
    endcase
  end

  // Unsigned: borrow clamps to zero, carry clamps to all ones
  assign clamp_uns = sub_i ? '0 : {4{`SIMD_SAT_U8_MAX}};

  always_comb begin
    int         top;
    logic [1:0] hi;
    logic [7:0] clamp_byte;

    for (int b = 0; b < `SIMD_LANES; b++) begin
      // Byte slice holding this lane's extension bit
      top = width32 ? 3 : (width8 ? b : (b | 1));
      hi  = byte_sums_i[top][8:7];

      // Signed overflow when the two top bits differ
      lane_sat_o[b] = signed_ops_i ? (hi[1] ^ hi[0]) : (hi[1] ^ sub_i);

      if (signed_ops_i) begin
        clamp_byte = hi[1] ? clamp_min[8*b +: 8] : clamp_max[8*b +: 8];
      end else begin
        clamp_byte = clamp_uns[8*b +: 8];
      end
      sat_result_o[8*b +: 8] = lane_sat_o[b] ? clamp_byte : byte_sums_i[b][7:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Halving
  ////////////////////////////////////////////////////////////////////////////
  // Unsigned difference keeps a not-borrow in bit 8, so flip it
  assign half_flip = ~signed_ops_i & sub_i;
  assign next_lsb  = {1'b0, byte_sums_i[3][0], byte_sums_i[2][0], byte_sums_i[1][0]};

  always_comb begin
    for (int b = 0; b < `SIMD_LANES; b++) begin
      half_result_o[8*b+7]   = lane_top[b] ? (byte_sums_i[b][8] ^ half_flip) : next_lsb[b];
      half_result_o[8*b +: 7] = byte_sums_i[b][7:1];
    end
  end

endmodule

// ==== source/simd_compare.sv ====
////////////////////////////////////////////////////////////////////////////
// Lane compare masks and min/max select, working from A minus B
// Expects the adder to run a subtraction for every compare operation
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

`include "simd_params.svh"

module simd_compare
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  input  simd_byte_sums_t       byte_sums_i,
  input  simd_width_e           width_i,
  input  logic                  signed_ops_i,
  input  logic                  cmp_or_eq_i,
  input  logic                  cmp_invert_i,
  output logic [`SIMD_XLEN-1:0] cmp_result_o,
  output logic [`SIMD_XLEN-1:0] minmax_result_o
);

  simd_lane_flags_t byte_eq;
  simd_lane_flags_t byte_less;
  simd_lane_flags_t is_eq;
  simd_lane_flags_t is_less;
  simd_lane_flags_t flag;

  ////////////////////////////////////////////////////////////////////////////
  // Per byte flags
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    logic sign_a;
    logic sign_b;

    for (int b = 0; b < `SIMD_LANES; b++) begin
      sign_a     = operand_a_i[8*b+7];
      sign_b     = operand_b_i[8*b+7];
      byte_eq[b] = (byte_sums_i[b][7:0] == 8'h00);

      // Differing signs: the difference may have wrapped
      if (sign_a ^ sign_b) begin
        byte_less[b] = ~(sign_a ^ signed_ops_i);
      end else begin
        byte_less[b] = byte_sums_i[b][7];
      end
    end
  end

  // Spread over the lane, less from its top byte
  always_comb begin
    unique case (width_i)
      W8: begin
        is_eq   = byte_eq;
        is_less = byte_less;
      end
      W16: begin
        is_eq   = {{2{&byte_eq[3:2]}}, {2{&byte_eq[1:0]}}};
        is_less = {{2{byte_less[3]}}, {2{byte_less[1]}}};
      end
      default: begin
        is_eq   = {4{&byte_eq}};
        is_less = {4{byte_less[3]}};
      end
    endcase
  end

  always_comb begin
    unique case ({cmp_or_eq_i, cmp_invert_i})
      2'b00:   flag = is_less;
      2'b01:   flag = ~is_less;
      2'b10:   flag = is_less | is_eq;
      default: flag = is_eq;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Masks and selection
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int b = 0; b < `SIMD_LANES; b++) begin
      cmp_result_o[8*b +: 8]    = {8{flag[b]}};
      minmax_result_o[8*b +: 8] = flag[b] ? operand_a_i[8*b +: 8] : operand_b_i[8*b +: 8];
    end
  end

endmodule

// ==== source/simd_result_reg.sv ====
////////////////////////////////////////////////////////////////////////////
// Result select and output register stage, one cycle of latency
// No back-pressure; the result holds until the next valid operation
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

`include "simd_params.svh"

module simd_result_reg
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  simd_res_sel_e         res_sel_i,
  input  logic [`SIMD_XLEN-1:0] sum_i,
  input  logic [`SIMD_XLEN-1:0] sat_i,
  input  logic [`SIMD_XLEN-1:0] half_i,
  input  logic [`SIMD_XLEN-1:0] cmp_i,
  input  logic [`SIMD_XLEN-1:0] minmax_i,
  input  simd_lane_flags_t      lane_sat_i,
  output logic                  valid_o,
  output logic [`SIMD_XLEN-1:0] result_o,
  output logic                  set_ov_o
);

  logic [`SIMD_XLEN-1:0] result_d;
  logic                  set_ov_d;

  always_comb begin
    unique case (res_sel_i)
      RES_SAT:    result_d = sat_i;
      RES_HALF:   result_d = half_i;
      RES_CMP:    result_d = cmp_i;
      RES_MINMAX: result_d = minmax_i;
      default:    result_d = sum_i;
    endcase
  end

  // Overflow only counts for saturating ops
  assign set_ov_d = (res_sel_i == RES_SAT) & (|lane_sat_i);

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      set_ov_o <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o  <= valid_i;
      // Flag drops with valid so it never outlives its result
      set_ov_o <= valid_i & set_ov_d;
      if (valid_i) begin
        result_o <= result_d;
      end
    end
  end

endmodule

// ==== source/simd_alu_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Packed-SIMD add/sub/compare unit with one output register stage
// One operation per cycle, result one cycle later; no handshake
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

`include "simd_params.svh"

module simd_alu_top
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  simd_op_e              op_i,
  input  simd_width_e           width_i,
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  output logic                  valid_o,
  output logic [`SIMD_XLEN-1:0] result_o,
  output logic                  set_ov_o
);

  logic                  sub;
  logic                  signed_ops;
  simd_res_sel_e         res_sel;
  logic                  cmp_or_eq;
  logic                  cmp_invert;
  simd_byte_sums_t       byte_sums;
  logic [`SIMD_XLEN-1:0] sum;
  logic [`SIMD_XLEN-1:0] sat_result;
  logic [`SIMD_XLEN-1:0] half_result;
  logic [`SIMD_XLEN-1:0] cmp_result;
  logic [`SIMD_XLEN-1:0] minmax_result;
  simd_lane_flags_t      lane_sat;

  simd_op_decoder u_decoder (
    .op_i         (op_i),
    .sub_o        (sub),
    .signed_ops_o (signed_ops),
    .res_sel_o    (res_sel),
    .cmp_or_eq_o  (cmp_or_eq),
    .cmp_invert_o (cmp_invert)
  );

  simd_lane_adder u_adder (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .width_i      (width_i),
    .sub_i        (sub),
    .signed_ops_i (signed_ops),
    .byte_sums_o  (byte_sums),
    .sum_o        (sum)
  );

  simd_sat_round u_sat_round (
    .byte_sums_i   (byte_sums),
    .width_i       (width_i),
    .sub_i         (sub),
    .signed_ops_i  (signed_ops),
    .sat_result_o  (sat_result),
    .half_result_o (half_result),
    .lane_sat_o    (lane_sat)
  );

  simd_compare u_compare (
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .byte_sums_i     (byte_sums),
    .width_i         (width_i),
    .signed_ops_i    (signed_ops),
    .cmp_or_eq_i     (cmp_or_eq),
    .cmp_invert_i    (cmp_invert),
    .cmp_result_o    (cmp_result),
    .minmax_result_o (minmax_result)
  );

  simd_result_reg u_result_reg (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .res_sel_i  (res_sel),
    .sum_i      (sum),
    .sat_i      (sat_result),
    .half_i     (half_result),
    .cmp_i      (cmp_result),
    .minmax_i   (minmax_result),
    .lane_sat_i (lane_sat),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .set_ov_o   (set_ov_o)
  );

endmodule

// ==== verification/simd_alu_asserts.sv ====
////////////////////////////////////////////////////////////////////////////
// Timing checker bound into the top level of the packed-SIMD unit
// Assumes one-cycle latency and no back-pressure
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module simd_alu_asserts (
  input logic clk_i,
  input logic rst_n_i,
  input logic valid_i,
  input logic valid_o,
  input logic set_ov_o
);

  int assert_errors = 0;

  // valid_o is valid_i one cycle later
  valid_delay_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (valid_o == $past(valid_i)))
  else begin
    assert_errors++;
    $error("valid_o does not follow valid_i by one cycle");
  end

  // Quiet outputs in reset and in the cycle after it
  reset_quiet_a: assert property (@(posedge clk_i)
    (!rst_n_i || !$past(rst_n_i)) |-> (!valid_o && !set_ov_o))
  else begin
    assert_errors++;
    $error("valid_o or set_ov_o high during or just after reset");
  end

  set_ov_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    set_ov_o |-> valid_o)
  else begin
    assert_errors++;
    $error("set_ov_o high while valid_o is low");
  end

endmodule

bind simd_alu_top simd_alu_asserts u_asserts (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .valid_i  (valid_i),
  .valid_o  (valid_o),
  .set_ov_o (set_ov_o)
);

// ==== verification/simd_alu_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the packed-SIMD unit, expected results kept in issue order
// Outputs sampled at the falling edge; timing rules live in the bound checker
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

`include "simd_params.svh"

module simd_alu_tb
  import simd_op_pkg::*;
();

  localparam int          CLK_PERIOD    = 40;
  localparam int          DRIVE_DLY     = 5;
  localparam int          RESET_CYCLES  = 3;
  localparam int          RANDOM_PER_OP = 16;
  localparam int          DRAIN_CYCLES  = 10;
  localparam int          MAX_CYCLES    = 20000;
  localparam logic [31:0] LFSR_SEED     = 32'd17184;
  localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  valid_i;
  simd_op_e              op_i;
  simd_width_e           width_i;
  logic [`SIMD_XLEN-1:0] operand_a_i;
  logic [`SIMD_XLEN-1:0] operand_b_i;
  logic                  valid_o;
  logic [`SIMD_XLEN-1:0] result_o;
  logic                  set_ov_o;

  logic [`SIMD_XLEN-1:0] exp_res_q[$];
  logic                  exp_ov_q[$];
  logic [`SIMD_XLEN-1:0] exp_res;
  logic                  exp_ov;
  logic [31:0]           lfsr_state;
  int                    check_errors;
  int                    other_errors;

  simd_alu_top u_simd_alu_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .width_i     (width_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .set_ov_o    (set_ov_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits       = {bits[30:0], lfsr_state[0]};
    end
  endtask

  function automatic int lane_width(input simd_width_e width);
    case (width)
      W8:      return 8;
      W16:     return 16;
      default: return 32;
    endcase
  endfunction

  // Signed min, signed max, all ones, one, zero; rotated from lane to lane
  function automatic logic [31:0] corner_word(input simd_width_e width, input int idx);
    int     lw;
    longint lane_val;
    longint word;
    lw   = lane_width(width);
    word = 0;
    for (int l = 0; l < 32 / lw; l++) begin
      case ((idx + l) % 5)
        0:       lane_val = longint'(1) << (lw - 1);
        1:       lane_val = (longint'(1) << (lw - 1)) - 1;
        2:       lane_val = (longint'(1) << lw) - 1;
        3:       lane_val = 1;
        default: lane_val = 0;
      endcase
      word = word | (lane_val << (l * lw));
    end
    return word[31:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Behavioral lane model
  ////////////////////////////////////////////////////////////////////////////
  function automatic void compute_expected(input simd_op_e op, input simd_width_e width,
                                           input logic [31:0] a, input logic [31:0] b,
                                           output logic [31:0] res, output logic ov);
    int     lw;
    longint umax;
    longint smax;
    longint smin;
    longint ua;
    longint ub;
    longint sa;
    longint sb;
    longint r;
    longint acc;
    lw   = lane_width(width);
    umax = (longint'(1) << lw) - 1;
    smax = (longint'(1) << (lw - 1)) - 1;
    smin = -smax - 1;
    acc  = 0;
    ov   = 1'b0;
    for (int l = 0; l < 32 / lw; l++) begin
      ua = (longint'(a) >> (l * lw)) & umax;
      ub = (longint'(b) >> (l * lw)) & umax;
      sa = (ua > smax) ? ua - umax - 1 : ua;
      sb = (ub > smax) ? ub - umax - 1 : ub;
      case (op)
        ADD:     r = ua + ub;
        SUB:     r = ua - ub;
        KADD:    r = sa + sb;
        KSUB:    r = sa - sb;
        UKADD:   r = ua + ub;
        UKSUB:   r = ua - ub;
        RADD:    r = (sa + sb) >>> 1;
        RSUB:    r = (sa - sb) >>> 1;
        URADD:   r = (ua + ub) >>> 1;
        URSUB:   r = (ua - ub) >>> 1;
        CMPEQ:   r = (ua == ub) ? umax : 0;
        SCMPLT:  r = (sa < sb) ? umax : 0;
        SCMPLE:  r = (sa <= sb) ? umax : 0;
        UCMPLT:  r = (ua < ub) ? umax : 0;
        UCMPLE:  r = (ua <= ub) ? umax : 0;
        SMIN:    r = (sa < sb) ? sa : sb;
        SMAX:    r = (sa > sb) ? sa : sb;
        UMIN:    r = (ua < ub) ? ua : ub;
        UMAX:    r = (ua > ub) ? ua : ub;
        default: r = 0;
      endcase
      // Clamp to the lane range
      if ((op == KADD || op == KSUB) && (r > smax || r < smin)) begin
        r  = (r > smax) ? smax : smin;
        ov = 1'b1;
      end
      if ((op == UKADD || op == UKSUB) && (r > umax || r < 0)) begin
        r  = (r > umax) ? umax : 0;
        ov = 1'b1;
      end
      acc = acc | ((r & umax) << (l * lw));
    end
    res = acc[31:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////////////////////
  task automatic issue(input simd_op_e op, input simd_width_e width,
                       input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    logic        ov;
    @(posedge clk_i);
    #DRIVE_DLY;
    valid_i     = 1'b1;
    op_i        = op;
    width_i     = width;
    operand_a_i = a;
    operand_b_i = b;
    compute_expected(op, width, a, b, res, ov);
    exp_res_q.push_back(res);
    exp_ov_q.push_back(ov);
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
    valid_i = 1'b0;
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i && valid_o) begin
      if (exp_res_q.size() == 0) begin
        other_errors++;
        $display("Result returned at t=%0t with no operation outstanding", $time);
      end else begin
        exp_res = exp_res_q.pop_front();
        exp_ov  = exp_ov_q.pop_front();
        result_check: assert (result_o === exp_res) else begin
          check_errors++;
          $display("CHECK FAILED t=%0t result_o got %h expected %h",
                   $time, result_o, exp_res);
        end
        ov_check: assert (set_ov_o === exp_ov) else begin
          check_errors++;
          $display("CHECK FAILED t=%0t set_ov_o got %b expected %b",
                   $time, set_ov_o, exp_ov);
        end
      end
    end
  end

  // Watchdog on the whole run
  initial begin
    for (int c = 0; c < MAX_CYCLES; c++) begin
      @(posedge clk_i);
    end
    $display("Run did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rand_a;
    logic [31:0] rand_b;
    logic [31:0] gap;
    lfsr_state   = LFSR_SEED;
    check_errors = 0;
    other_errors = 0;
    rst_n_i      = 1'b0;
    valid_i      = 1'b0;
    op_i         = ADD;
    width_i      = W8;
    operand_a_i  = '0;
    operand_b_i  = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;

    // Corner pairs for every op at every width, back to back
    for (int w = 0; w < 3; w++) begin
      for (int o = 0; o <= int'(UMAX); o++) begin
        for (int i = 0; i < 5; i++) begin
          for (int j = 0; j < 5; j++) begin
            issue(simd_op_e'(o), simd_width_e'(w),
                  corner_word(simd_width_e'(w), i), corner_word(simd_width_e'(w), j));
          end
        end
      end
    end

    // Random operands with occasional idle gaps
    for (int w = 0; w < 3; w++) begin
      for (int o = 0; o <= int'(UMAX); o++) begin
        for (int n = 0; n < RANDOM_PER_OP; n++) begin
          take_bits(32, rand_a);
          take_bits(32, rand_b);
          take_bits(2, gap);
          if (gap == 0) begin
            idle_cycle();
          end
          issue(simd_op_e'(o), simd_width_e'(w), rand_a, rand_b);
        end
      end
    end

    idle_cycle();
    for (int c = 0; c < DRAIN_CYCLES && exp_res_q.size() != 0; c++) begin
      @(posedge clk_i);
    end
    if (exp_res_q.size() != 0) begin
      other_errors++;
      $display("Timed out with %0d results still outstanding", exp_res_q.size());
    end

    $display("Error counts: value checks %0d, other %0d, timing assertions %0d",
             check_errors, other_errors, u_simd_alu_top.u_asserts.assert_errors);
    if (check_errors + other_errors + u_simd_alu_top.u_asserts.assert_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+source
source/simd_op_pkg.sv
source/simd_lane_pkg.sv
source/simd_op_decoder.sv
source/simd_lane_adder.sv
source/simd_sat_round.sv
source/simd_compare.sv
source/simd_result_reg.sv
source/simd_alu_top.sv
verification/simd_alu_asserts.sv
verification/simd_alu_tb.sv

// ==== Makefile ====
SIM        = verilator
TOP        = simd_alu_tb
LINT_TOP   = simd_alu_top
FILELIST   = project.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
RUN_ARGS   = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
